/* mem_stage.f */
+incdir+include
hw/mem_op_pkg.sv
hw/mem_port_pkg.sv
hw/load_extract.sv
hw/store_merge.sv
hw/access_sequencer.sv
hw/stage_register.sv
hw/mem_stage.sv
test/data_mem_model.sv
test/mem_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module mem_stage_tb -f mem_stage.f &&
{ ./obj_dir/Vmem_stage_tb > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -qx "Test OK" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

/* test/mem_stage_tb.sv */
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module mem_stage_tb;

  import mem_op_pkg::*;
  import mem_port_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_OPS      = 120;  // bound on bundles issued by all tests
  localparam int MAX_LATENCY  = 5;    // cycles from request to done
  localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_OPS * 20 * MAX_LATENCY) * CLK_PERIOD;

  logic       clk = 1'b0;
  logic       reset;
  logic       enable;
  logic       flush;
  mm_bundle_t bundle_in;
  logic       ready;
  mm_result_t result;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;

  always #(CLK_PERIOD/2) clk = ~clk;

  mem_stage dut (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .flush     (flush),
    .bundle_in (bundle_in),
    .ready     (ready),
    .result    (result),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
  );

  data_mem_model u_mem (
    .clk     (clk),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(string what);
    $display("ERROR: %s", what);
    abort_run();
  endtask

  task automatic value_mismatch(string name, logic [63:0] exp, logic [63:0] got);
    $display("FAIL %s: expected %h, actual %h", name, exp, got);
    abort_run();
  endtask

  task automatic bundle_mismatch(string name, mm_bundle_t exp, mm_bundle_t got);
    $display("FAIL %s: expected bundle %h, actual %h", name, exp, got);
    abort_run();
  endtask

  function automatic logic [63:0] peek_word(logic [63:0] addr);
    return u_mem.mem[addr[10:3]];
  endfunction

  function automatic int access_bytes(mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default:              return 8;
    endcase
  endfunction

  function automatic logic [63:0] expected_load(mem_op_e op, logic [63:0] word, int lane);
    int          n;
    int          first;
    logic [63:0] val;
    n     = access_bytes(op);
    first = (lane / n) * n;  // natural alignment of the access
    val   = '0;
    for (int k = 0; k < n; k++) begin
      val[k*8 +: 8] = word[(first + k)*8 +: 8];
    end
    if ((op == op_lb || op == op_lh || op == op_lw) && val[n*8-1]) begin
      for (int k = n; k < 8; k++) begin
        val[k*8 +: 8] = 8'hff;
      end
    end
    return val;
  endfunction

  function automatic logic [63:0] expected_store(mem_op_e op, logic [63:0] old,
                                                 int lane, logic [63:0] value);
    int          n;
    int          first;
    logic [63:0] word;
    n     = access_bytes(op);
    first = (lane / n) * n;
    word  = old;
    for (int k = 0; k < n; k++) begin
      word[(first + k)*8 +: 8] = value[k*8 +: 8];
    end
    return word;
  endfunction

  function automatic mm_bundle_t make_bundle(mem_op_e op, logic [63:0] addr,
                                             logic [63:0] value);
    mm_bundle_t b;
    logic       loads;
    loads          = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
    b.op           = op;
    b.rd_regno     = addr[7:3];
    b.update_rd    = loads || (op == op_none);
    b.mm_load      = loads;
    b.branch_taken = 1'b0;
    b.pc_target    = 64'h8000_0000 + addr;
    b.alu_result   = addr;
    b.rs2_value    = value;
    return b;
  endfunction

  function automatic logic write_expected(mem_op_e op, logic read_done);
    case (op)
      op_sd:               return 1'b1;
      op_sb, op_sh, op_sw: return read_done;  // read-modify-write
      default:             return 1'b0;
    endcase
  endfunction

  // follows the memory port of one bundle until ready
  task automatic wait_ready(string name, mm_bundle_t b);
    logic [63:0] word_addr;
    logic        read_done;
    word_addr = b.alu_result & ~64'd7;
    read_done = 1'b0;
    do begin
      @(negedge clk);
      if (mem_req.valid) begin
        assert (b.op != op_none)
          else report_error({name, ": request from a non-memory op"});
        assert (mem_req.addr == word_addr)
          else value_mismatch({name, " address"}, word_addr, mem_req.addr);
        assert (mem_req.write == write_expected(b.op, read_done))
          else report_error({name, ": memory request in the wrong direction"});
        read_done = read_done || (mem_rsp.done && !mem_req.write);
      end
    end while (!ready);
  endtask

  // one bundle from enable to the captured result
  task automatic run_op(string name, mem_op_e op, logic [63:0] addr, logic [63:0] value,
                        logic [63:0] exp_mdata);
    mm_bundle_t b;
    b         = make_bundle(op, addr, value);
    bundle_in = b;
    enable    = 1'b1;
    wait_ready(name, b);
    @(posedge clk);
    #DRIVE_DELAY;
    enable    = 1'b0;
    bundle_in = '0;
    assert (result.bundle == b) else bundle_mismatch(name, b, result.bundle);
    assert (result.mdata == exp_mdata) else value_mismatch(name, exp_mdata, result.mdata);
  endtask

  task automatic check_after_reset();
    assert (result.bundle == '0) else bundle_mismatch("after reset", '0, result.bundle);
    assert (result.mdata == '0) else value_mismatch("after reset", '0, result.mdata);
    assert (!mem_req.valid) else report_error("memory request active after reset");
  endtask

  task automatic check_passthrough();
    mm_bundle_t b;
    b         = make_bundle(op_none, 64'h1234, 64'h0bad_f00d_dead_beef);
    bundle_in = b;
    enable    = 1'b1;
    @(negedge clk);
    assert (ready) else report_error("op_none did not raise ready in its enable cycle");
    assert (!mem_req.valid) else report_error("op_none issued a memory request");
    @(posedge clk);
    #DRIVE_DELAY;
    enable    = 1'b0;
    bundle_in = '0;
    assert (result.bundle == b) else bundle_mismatch("passthrough", b, result.bundle);
    assert (result.mdata == '0) else value_mismatch("passthrough", '0, result.mdata);
  endtask

  task automatic check_sd_readback();
    logic [63:0] addr;
    logic [63:0] value;
    addr  = 64'h20;
    value = 64'h80ff_7f01_c3a5_5a3c;  // mixed sign bits in every lane size
    run_op("sd", op_sd, addr, value, '0);
    assert (peek_word(addr) == value) else value_mismatch("sd word", value, peek_word(addr));
    run_op("sd readback", op_ld, addr, 64'd0, value);
  endtask

  task automatic check_load_lanes();
    mem_op_e     load_ops [7];
    logic [63:0] addr;
    int          step;
    load_ops = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
    for (int w = 4; w <= 5; w++) begin
      for (int i = 0; i < 7; i++) begin
        step = access_bytes(load_ops[i]);
        for (int lane = 0; lane < 8; lane += step) begin
          addr = 64'(w) * 64'd8 + 64'(lane);
          run_op($sformatf("%s word %0d lane %0d", load_ops[i].name(), w, lane),
                 load_ops[i], addr, 64'd0, expected_load(load_ops[i], peek_word(addr), lane));
        end
      end
    end
  endtask

  // every lane, including misaligned ones where low offset bits are dropped
  task automatic check_store_lanes();
    mem_op_e     store_ops [3];
    logic [63:0] addr;
    logic [63:0] value;
    logic [63:0] exp;
    string       name;
    store_ops = '{op_sb, op_sh, op_sw};
    for (int i = 0; i < 3; i++) begin
      for (int lane = 0; lane < 8; lane++) begin
        addr  = 64'(8 + i) * 64'd8 + 64'(lane);
        value = 64'hf1e2_d3c4_b5a6_9788 + 64'(lane) * 64'h0101_0101_0101_0101;
        exp   = expected_store(store_ops[i], peek_word(addr), lane, value);
        name  = $sformatf("%s lane %0d", store_ops[i].name(), lane);
        run_op(name, store_ops[i], addr, value, '0);
        assert (peek_word(addr) == exp) else value_mismatch(name, exp, peek_word(addr));
        run_op({name, " readback"}, op_ld, addr, 64'd0, exp);
      end
    end
  endtask

  task automatic check_flush();
    logic [63:0] addr;
    addr      = 64'h30;
    bundle_in = make_bundle(op_ld, addr, 64'd0);
    enable    = 1'b1;
    @(negedge clk);
    assert (!ready) else report_error("load finished before the flush could hit it");
    @(posedge clk);
    #DRIVE_DELAY;
    flush = 1'b1;
    @(negedge clk);
    assert (!mem_req.valid) else report_error("memory request stayed active during flush");
    assert (ready) else report_error("ready low during flush");
    @(posedge clk);
    #DRIVE_DELAY;
    flush     = 1'b0;
    enable    = 1'b0;
    bundle_in = '0;
    assert (result.bundle == '0) else bundle_mismatch("flush", '0, result.bundle);
    assert (result.mdata == '0) else value_mismatch("flush", '0, result.mdata);
    run_op("load after flush", op_ld, addr, 64'd0, peek_word(addr));
  endtask

  initial begin
    reset     = 1'b1;
    enable    = 1'b0;
    flush     = 1'b0;
    bundle_in = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    check_after_reset();
    check_passthrough();
    check_sd_readback();
    check_load_lanes();
    check_store_lanes();
    check_flush();
    $display("Test OK");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    report_error("watchdog timeout, the DUT stopped answering");
  end

endmodule

/* test/data_mem_model.sv */
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module data_mem_model (
  input  logic                    clk,
  input  logic                    reset,
  input  mem_port_pkg::mem_req_t  mem_req,
  output mem_port_pkg::mem_rsp_t  mem_rsp
);

  localparam int MEM_WORDS = 256;

  logic [`MM_DATA_W-1:0] mem [0:MEM_WORDS-1];
  logic [7:0]            idx;
  logic                  pending;
  logic [1:0]            wait_cnt;  // wait states still to go
  logic [31:0]           draw;
  integer                seed = 32'hd75e2bdf;

  // every word differs, hashed from its full index
  function automatic logic [`MM_DATA_W-1:0] fill_word(int i);
    return (64'(i) + 64'd1) * 64'h9e37_79b9_7f4a_7c15;
  endfunction

  assign idx = mem_req.addr[10:3];

  // done comes 1 to 4 cycles after the request is taken
  always @(posedge clk) begin
    if (reset) begin
      pending  <= 1'b0;
      wait_cnt <= '0;
      mem_rsp  <= '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= fill_word(i);
      end
    end else begin
      mem_rsp.done <= 1'b0;
      if (pending && !mem_req.valid) begin
        pending <= 1'b0;  // request withdrawn by a flush
      end else if (pending) begin
        if (wait_cnt == 2'd0) begin
          mem_rsp.done  <= 1'b1;
          mem_rsp.rdata <= mem[idx];
          pending       <= 1'b0;
          if (mem_req.write) begin
            mem[idx] <= mem_req.wdata;
          end
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end else if (mem_req.valid && !mem_rsp.done) begin
        draw     = $random(seed);
        pending  <= 1'b1;
        wait_cnt <= draw[1:0];
      end
    end
  end

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module mem_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    enable,
  input  logic                    flush,
  input  mem_op_pkg::mm_bundle_t  bundle_in,
  output logic                    ready,
  output mem_op_pkg::mm_result_t  result,
  output mem_port_pkg::mem_req_t  mem_req,
  input  mem_port_pkg::mem_rsp_t  mem_rsp
);

  logic [`MM_LANE_W-1:0] lane;
  logic [`MM_DATA_W-1:0] held_word;
  logic [`MM_DATA_W-1:0] merged_word;
  logic [`MM_DATA_W-1:0] mdata;

  assign lane = bundle_in.alu_result[`MM_LANE_W-1:0];

  access_sequencer u_seq (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .flush        (flush),
    .op           (bundle_in.op),
    .addr         (bundle_in.alu_result),
    .merged_word  (merged_word),
    .mem_req      (mem_req),
    .mem_rsp_done (mem_rsp.done),
    .read_word_in (mem_rsp.rdata),
    .held_word    (held_word),
    .ready        (ready)
  );

  store_merge u_merge (
    .op          (bundle_in.op),
    .lane        (lane),
    .store_value (bundle_in.rs2_value),
    .held_word   (held_word),
    .merged_word (merged_word)
  );

  // reads straight off the response, the stage register samples it on done
  load_extract u_extract (
    .op    (bundle_in.op),
    .lane  (lane),
    .word  (mem_rsp.rdata),
    .mdata (mdata)
  );

  stage_register u_out (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .flush     (flush),
    .ready     (ready),
    .bundle_in (bundle_in),
    .mdata     (mdata),
    .result    (result)
  );

endmodule

/* hw/stage_register.sv */
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module stage_register (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    enable,
  input  logic                    flush,
  input  logic                    ready,
  input  mem_op_pkg::mm_bundle_t  bundle_in,
  input  logic [`MM_DATA_W-1:0]   mdata,
  output mem_op_pkg::mm_result_t  result
);

  logic capture;

  // the stage is done with the current bundle
  assign capture = enable && ready;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      result <= '0;  // flushed slot looks like a bubble to write-back
    end else if (capture) begin
      result.bundle <= bundle_in;
      result.mdata  <= mdata;
    end
  end

endmodule

/* hw/access_sequencer.sv */
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module access_sequencer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    enable,
  input  logic                    flush,
  input  mem_op_pkg::mem_op_e     op,
  input  logic [`MM_ADDR_W-1:0]   addr,
  input  logic [`MM_DATA_W-1:0]   merged_word,
  output mem_port_pkg::mem_req_t  mem_req,
  input  logic                    mem_rsp_done,
  input  logic [`MM_DATA_W-1:0]   read_word_in,
  output logic [`MM_DATA_W-1:0]   held_word,
  output logic                    ready
);

  import mem_op_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write
  } seq_state_e;

  seq_state_e state;
  seq_state_e next_state;
  seq_state_e phase;      // phase acted on this cycle
  logic       is_load;
  logic       capture_read;

  assign is_load = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};

  // idle issues the first access of a new op in the same cycle
  always_comb begin
    phase = state;
    if (state == st_idle) begin
      case (op)
        op_lb, op_lbu, op_lh, op_lhu,
        op_lw, op_lwu, op_ld,
        op_sb, op_sh, op_sw: phase = st_read;  // sub-word stores read first
        op_sd:               phase = st_write;
        default:             phase = st_idle;
      endcase
    end
  end

  always_comb begin
    mem_req       = '0;
    mem_req.valid = enable && !flush && (phase != st_idle);
    mem_req.write = (phase == st_write);
    mem_req.addr  = {addr[`MM_ADDR_W-1:`MM_LANE_W], {`MM_LANE_W{1'b0}}};
    if (phase == st_write) begin
      mem_req.wdata = merged_word;
    end
  end

  always_comb begin
    if (flush || !enable) begin
      ready = 1'b1;
    end else begin
      case (phase)
        st_read:  ready = mem_rsp_done && is_load;
        st_write: ready = mem_rsp_done;
        default:  ready = 1'b1;  // non-memory op
      endcase
    end
  end

  always_comb begin
    next_state = state;
    if (flush) begin
      next_state = st_idle;
    end else if (enable) begin
      next_state = phase;
      if (mem_rsp_done) begin
        case (phase)
          st_read:  next_state = is_load ? st_idle : st_write;
          st_write: next_state = st_idle;
          default:  next_state = st_idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  assign capture_read = enable && !flush && (phase == st_read) && mem_rsp_done;

  // old word for the read-modify-write
  always_ff @(posedge clk) begin
    if (capture_read) begin
      held_word <= read_word_in;
    end
  end

endmodule

/* hw/store_merge.sv */
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module store_merge (
  input  mem_op_pkg::mem_op_e     op,
  input  logic [`MM_LANE_W-1:0]   lane,
  input  logic [`MM_DATA_W-1:0]   store_value,
  input  logic [`MM_DATA_W-1:0]   held_word,
  output logic [`MM_DATA_W-1:0]   merged_word
);

  import mem_op_pkg::*;

  localparam int NUM_BYTES = `MM_DATA_W / 8;

  logic [`MM_LANE_W-1:0] offset;
  logic [NUM_BYTES-1:0]  size_mask;
  logic [NUM_BYTES-1:0]  byte_mask;
  logic [`MM_DATA_W-1:0] placed;

  assign offset = lane_offset(op, lane);

  always_comb begin
    case (op)
      op_sb:   size_mask = 8'h01;
      op_sh:   size_mask = 8'h03;
      op_sw:   size_mask = 8'h0f;
      op_sd:   size_mask = 8'hff;
      default: size_mask = 8'h00;  // nothing written
    endcase
  end

  assign byte_mask = size_mask << offset;
  assign placed    = store_value << {offset, 3'b000};

  always_comb begin
    for (int i = 0; i < NUM_BYTES; i++) begin
      merged_word[i*8 +: 8] = byte_mask[i] ? placed[i*8 +: 8] : held_word[i*8 +: 8];
    end
  end

endmodule

/* hw/load_extract.sv */
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module load_extract (
  input  mem_op_pkg::mem_op_e     op,
  input  logic [`MM_LANE_W-1:0]   lane,
  input  logic [`MM_DATA_W-1:0]   word,
  output logic [`MM_DATA_W-1:0]   mdata
);

  import mem_op_pkg::*;

  logic [`MM_LANE_W-1:0] offset;
  logic [`MM_DATA_W-1:0] shifted;  // addressed lane moved down to bit 0

  assign offset  = lane_offset(op, lane);
  assign shifted = word >> {offset, 3'b000};

  always_comb begin
    case (op)
      op_lb: begin
        mdata = {{(`MM_DATA_W-8){shifted[7]}}, shifted[7:0]};
      end
      op_lbu: begin
        mdata = {{(`MM_DATA_W-8){1'b0}}, shifted[7:0]};
      end
      op_lh: begin
        mdata = {{(`MM_DATA_W-16){shifted[15]}}, shifted[15:0]};
      end
      op_lhu: begin
        mdata = {{(`MM_DATA_W-16){1'b0}}, shifted[15:0]};
      end
      op_lw: begin
        mdata = {{(`MM_DATA_W-32){shifted[31]}}, shifted[31:0]};
      end
      op_lwu: begin
        mdata = {{(`MM_DATA_W-32){1'b0}}, shifted[31:0]};
      end
      op_ld:   mdata = word;
      default: mdata = '0;  // stores and non-memory ops
    endcase
  end

endmodule

/* hw/mem_port_pkg.sv */
`include "mem_stage_consts.svh"

package mem_port_pkg;

  // held until the done cycle of the response
  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [`MM_ADDR_W-1:0]  addr;   // word aligned
    logic [`MM_DATA_W-1:0]  wdata;
  } mem_req_t;

  typedef struct packed {
    logic                   done;   // one cycle pulse
    logic [`MM_DATA_W-1:0]  rdata;  // valid with done on reads
  } mem_rsp_t;

endpackage

/* hw/mem_op_pkg.sv */
`include "mem_stage_consts.svh"

package mem_op_pkg;

  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lbu  = 4'd2,
    op_lh   = 4'd3,
    op_lhu  = 4'd4,
    op_lw   = 4'd5,
    op_lwu  = 4'd6,
    op_ld   = 4'd7,
    op_sb   = 4'd8,
    op_sh   = 4'd9,
    op_sw   = 4'd10,
    op_sd   = 4'd11
  } mem_op_e;

  typedef struct packed {
    mem_op_e                 op;
    logic [`MM_REGNO_W-1:0]  rd_regno;
    logic                    update_rd;
    logic                    mm_load;
    logic                    branch_taken;
    logic [`MM_ADDR_W-1:0]   pc_target;
    logic [`MM_DATA_W-1:0]   alu_result;  // byte address for loads and stores
    logic [`MM_DATA_W-1:0]   rs2_value;   // store data
  } mm_bundle_t;

  typedef struct packed {
    mm_bundle_t              bundle;
    logic [`MM_DATA_W-1:0]   mdata;
  } mm_result_t;

  // first byte of the accessed lane, low offset bits dropped for wider sizes
  function automatic logic [`MM_LANE_W-1:0] lane_offset(mem_op_e op,
                                                        logic [`MM_LANE_W-1:0] lane);
    case (op)
      op_lb, op_lbu, op_sb: lane_offset = lane;
      op_lh, op_lhu, op_sh: lane_offset = {lane[2:1], 1'b0};
      op_lw, op_lwu, op_sw: lane_offset = {lane[2], 2'b00};
      default:              lane_offset = '0;
    endcase
  endfunction

endpackage

/* include/mem_stage_consts.svh */
`ifndef MEM_STAGE_CONSTS_SVH
`define MEM_STAGE_CONSTS_SVH

// data word of the memory port and of the register file
`define MM_DATA_W 64

// byte address as produced by the alu
`define MM_ADDR_W 64

// architectural register number
`define MM_REGNO_W 5

// byte offset inside one data word
`define MM_LANE_W 3

`endif
